//--- all.f
source/display_pkg.sv
source/tube_pkg.sv
source/display_if.sv
source/value_intake.sv
source/bcd_converter.sv
source/seven_seg_scan.sv
source/display_top.sv
sim/display_tb.sv

//--- run.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module display_tb -f all.f

out=$(./obj_dir/Vdisplay_tb 2>&1) || true
echo "$out"
echo "$out" | grep -q "STATUS: PASS"

//--- sim/display_tb.sv
`timescale 1ns/1ps

module display_tb;
    import display_pkg::*;

    localparam int val_w = value_width;
    localparam logic [6:0] blank_code = 7'h7f;
    // active-low codes for 0..9, segment g in bit 6
    localparam logic [6:0] seg_table [10] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19,
                                              7'h12, 7'h02, 7'h78, 7'h00, 7'h10};
    // converter slot for the request ahead, the queued one and this one, then a frame
    localparam int settle_cycles = 3 * (val_w + 1 + digit_count) + digit_count + 2;
    localparam int request_total = 21;

    logic             clk_tube;
    logic             rst_n;
    logic [val_w-1:0] in_value;
    display_mode_e    in_mode;
    logic             in_valid;
    logic             in_ready;
    logic             display_on;
    logic [6:0]       seg_tube;
    logic [7:0]       seg_enable;

    integer      seed = 32'hcb82_ed81;
    logic [31:0] rnd;
    int          cyc = 0;       // rising edges since reset release
    int          pos;
    logic        on_at_edge;    // display_on as the last edge saw it
    logic        frame_on;
    logic        saw_full = 1'b0;
    logic [55:0] cur_frame;
    logic [55:0] shown_frame;
    logic [55:0] acc_q [$];     // expected frames of accepted requests not yet on the tubes
    int          acc_cyc [$];

    display_top #(.val_w(val_w)) u_display_top (.*);

    initial begin
        clk_tube = 1'b0;
        forever #10 clk_tube = ~clk_tube;
    end

    task automatic report_error(input string msg);
        $display("[FAIL] %0t %s", $time, msg);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    // tube p holds digit 7-p, dark positions read as blank_code
    function automatic logic [55:0] expected_frame(input logic [val_w-1:0] value,
                                                   input display_mode_e mode);
        logic [55:0] frame;
        int          digit [8];
        int          rest;
        logic        lead;
        rest = value % 100_000_000;
        for (int i = 0; i < digit_count; i++) begin
            digit[i] = rest % 10;
            rest     = rest / 10;
        end
        lead = 1'b1;
        for (int p = 0; p < digit_count; p++) begin
            if (digit[7 - p] != 0 || p == 7) lead = 1'b0;
            if (mode == mode_binary) begin
                frame[7*p +: 7] = seg_table[value[7 - p]];
            end else begin
                frame[7*p +: 7] = lead ? blank_code : seg_table[digit[7 - p]];
            end
        end
        return frame;
    endfunction

    task automatic check_frame(input logic [55:0] got);
        if (acc_q.size() != 0 && got == acc_q[0]) begin
            shown_frame = acc_q.pop_front();
            void'(acc_cyc.pop_front());
        end else begin
            assert (got == shown_frame)
                else report_error($sformatf("frame %h, expected %h", got, shown_frame));
        end
    endtask

    task automatic wait_settled();
        while (acc_q.size() != 0) @(posedge clk_tube);
        repeat (2 * digit_count) @(posedge clk_tube);
        #2;
    endtask

    task automatic send_request(input logic [val_w-1:0] value, input display_mode_e mode,
                                input logic settle);
        logic got;
        in_value = value;
        in_mode  = mode;
        in_valid = 1'b1;
        got      = 1'b0;
        while (!got) begin
            @(negedge clk_tube);
            got = in_ready; // transfer happens on the coming edge
            @(posedge clk_tube);
            #2;
        end
        in_valid = 1'b0;
        acc_q.push_back(expected_frame(value, mode));
        acc_cyc.push_back(cyc);
        if (settle) wait_settled();
    endtask

    always @(posedge clk_tube) begin
        on_at_edge <= display_on;
        if (rst_n) cyc <= cyc + 1;
    end

    // outputs after edge k show scan position (k-1) mod 8
    always @(negedge clk_tube) begin
        if (cyc != 0) begin
            pos = (cyc - 1) % digit_count;
            if (pos == 0) frame_on = 1'b1;
            frame_on = frame_on && on_at_edge;
            if (!in_ready) saw_full = 1'b1;
            assert (seg_enable == 8'hff || seg_enable == ~(8'h01 << (7 - pos)))
                else report_error($sformatf("enable %b at position %0d", seg_enable, pos));
            assert (on_at_edge || seg_enable == 8'hff)
                else report_error("tube lit while display_on is low");
            assert (seg_enable != 8'hff || seg_tube == blank_code)
                else report_error($sformatf("segments %b on a dark position", seg_tube));
            assert (in_ready || acc_q.size() >= 2)
                else report_error("in_ready low with fewer than two requests pending");
            if (acc_q.size() != 0) begin
                assert (cyc - acc_cyc[0] <= settle_cycles)
                    else report_error("accepted value not shown within the settle bound");
            end
            cur_frame[7*pos +: 7] = (seg_enable == 8'hff) ? blank_code : seg_tube;
            if (pos == digit_count - 1 && frame_on) check_frame(cur_frame);
        end
    end

    initial begin
        repeat (60 * settle_cycles * request_total) @(posedge clk_tube);
        $display("watchdog expired, the test did not finish and the design seems to hang");
        $display("STATUS: FAIL");
        $fatal(1);
    end

    initial begin
        rst_n          = 1'b0;
        in_value       = '0;
        in_mode        = mode_decimal;
        in_valid       = 1'b0;
        display_on     = 1'b1;
        shown_frame    = {8{blank_code}};
        repeat (5) @(posedge clk_tube);
        #2;
        rst_n = 1'b1;
        repeat (3 * digit_count) @(posedge clk_tube); // dark until a value arrives
        #2;

        send_request(27'd0, mode_decimal, 1'b1);
        send_request(27'd7, mode_decimal, 1'b1);
        send_request(27'd10, mode_decimal, 1'b1);
        send_request(27'd99_999_999, mode_decimal, 1'b1);
        send_request(27'd100_000_005, mode_decimal, 1'b1);
        repeat (6) begin
            rnd = $random(seed);
            send_request(rnd[val_w-1:0], mode_decimal, 1'b1);
        end

        send_request(27'h00_00a5, mode_binary, 1'b1);
        send_request(27'h5a_5a00, mode_binary, 1'b1); // low byte all zero
        repeat (2) begin
            rnd = $random(seed);
            send_request(rnd[val_w-1:0], mode_binary, 1'b1);
        end

        repeat (3) @(posedge clk_tube); // drop display_on mid frame
        #2;
        display_on = 1'b0;
        repeat (3 * digit_count + 5) @(posedge clk_tube);
        #2;
        display_on = 1'b1;
        repeat (2 * digit_count + 1) @(posedge clk_tube);
        #2;

        for (int i = 0; i < 6; i++) begin
            rnd = $random(seed);
            send_request(rnd[val_w-1:0], rnd[31] ? mode_binary : mode_decimal, 1'b0);
        end
        wait_settled();
        assert (saw_full) else report_error("intake never filled under back-to-back requests");

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- source/display_top.sv
`timescale 1ns/1ps

module display_top #(
    parameter int val_w = display_pkg::value_width
) (
    input  logic                       clk_tube,
    input  logic                       rst_n,
    input  logic [val_w-1:0]           in_value,
    input  display_pkg::display_mode_e in_mode,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  logic                       display_on,  // from hazard logic
    output tube_pkg::seg_code_t        seg_tube,
    output logic [7:0]                 seg_enable
);

    display_req_if #(.val_w(val_w)) req_bus ();
    digit_bus_if                    dig_bus ();

    value_intake #(
        .val_w(val_w)
    ) u_intake (
        .clk_tube (clk_tube),
        .rst_n    (rst_n),
        .in_value (in_value),
        .in_mode  (in_mode),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .req      (req_bus.source)
    );

    bcd_converter #(
        .val_w(val_w)
    ) u_conv (
        .clk_tube (clk_tube),
        .rst_n    (rst_n),
        .req      (req_bus.sink),
        .dig      (dig_bus.source)
    );

    seven_seg_scan u_scan (
        .clk_tube   (clk_tube),
        .rst_n      (rst_n),
        .dig        (dig_bus.sink),
        .display_on (display_on),
        .seg_tube   (seg_tube),
        .seg_enable (seg_enable)
    );

endmodule

//--- source/seven_seg_scan.sv
`timescale 1ns/1ps

module seven_seg_scan (
    input  logic                clk_tube,
    input  logic                rst_n,
    digit_bus_if.sink           dig,
    input  logic                display_on,
    output tube_pkg::seg_code_t seg_tube,
    output logic [7:0]          seg_enable
);
    import display_pkg::*;
    import tube_pkg::*;

    scan_pos_t     pos;
    digit_vec_t    frame_digits;
    display_mode_e frame_mode;
    logic          frame_valid;  // nothing to show until the first frame lands
    logic          lz_q;         // still inside the leading zeros
    digit_t        cur_digit;
    logic          lead_in;
    logic          is_lead_zero;
    logic          blank_pos;
    logic          take;

    // new digits only at the last position, so each frame starts clean
    assign dig.ready = (pos == 3'd7);
    assign take      = dig.valid && dig.ready;

    always_comb begin
        cur_digit    = frame_digits[3'd7 - pos];
        lead_in      = (pos == 3'd0) ? 1'b1 : lz_q;
        is_lead_zero = lead_in && (cur_digit == 4'd0);
        blank_pos    = !display_on || !frame_valid ||
                       (frame_mode == mode_decimal && is_lead_zero && pos != 3'd7);
    end

    always_ff @(posedge clk_tube or negedge rst_n) begin
        if (!rst_n) begin
            pos          <= '0;
            lz_q         <= 1'b1;
            frame_digits <= '0;
            frame_mode   <= mode_decimal;
            frame_valid  <= 1'b0;
        end else begin
            pos  <= pos + 3'd1; // free running, wraps 7 -> 0
            lz_q <= is_lead_zero;
            if (take) begin
                frame_digits <= dig.digits;
                frame_mode   <= dig.mode;
                frame_valid  <= 1'b1;
            end
        end
    end

    // registered drive for the position just scanned
    always_ff @(posedge clk_tube or negedge rst_n) begin
        if (!rst_n) begin
            seg_enable <= enable_none;
            seg_tube   <= seg_blank;
        end else if (blank_pos) begin
            seg_enable <= enable_none;
            seg_tube   <= seg_blank;
        end else begin
            seg_enable <= ~(8'h01 << (3'd7 - pos));
            seg_tube   <= digit_to_seg(cur_digit);
        end
    end

    // never more than one tube lit
    one_tube_a: assert property (@(posedge clk_tube) disable iff (!rst_n)
        $onehot0(~seg_enable))
        else $error("bad tube enable pattern %b", seg_enable);

endmodule

//--- source/bcd_converter.sv
`timescale 1ns/1ps

module bcd_converter #(
    parameter int val_w = display_pkg::value_width
) (
    input  logic        clk_tube,
    input  logic        rst_n,
    display_req_if.sink req,
    digit_bus_if.source dig
);
    import display_pkg::*;

    typedef enum logic [1:0] {
        conv_idle,
        conv_shift,
        conv_hold
    } conv_state_e;

    localparam int bcd_digits = digit_count + 1; // spare top digit, dropped for mod 10^8
    localparam int step_w     = $clog2(val_w + 1);

    conv_state_e             state;
    logic [step_w-1:0]       steps_left;
    logic [val_w-1:0]        shift_val;
    display_mode_e           mode_q;
    logic [4*bcd_digits-1:0] bcd;
    logic [4*bcd_digits-1:0] bcd_adj;  // digits after the add-3 correction
    logic [4*bcd_digits-1:0] bin_load; // bit i of the value as digit i

    always_comb begin
        bcd_adj  = bcd;
        bin_load = '0;
        for (int i = 0; i < bcd_digits; i++) begin
            if (bcd[4*i +: 4] > 4'd4) begin
                bcd_adj[4*i +: 4] = bcd[4*i +: 4] + 4'd3;
            end
        end
        for (int i = 0; i < digit_count; i++) begin
            bin_load[4*i] = shift_val[i];
        end
    end

    always_ff @(posedge clk_tube or negedge rst_n) begin
        if (!rst_n) begin
            state      <= conv_idle;
            steps_left <= '0;
        end else begin
            case (state)
                conv_idle: begin
                    if (req.valid) begin
                        state      <= conv_shift;
                        steps_left <= step_w'(val_w);
                    end
                end
                conv_shift: begin
                    steps_left <= steps_left - 1'b1;
                    if (mode_q == mode_binary || steps_left == step_w'(1)) begin
                        state <= conv_hold;
                    end
                end
                conv_hold: begin
                    if (dig.ready) state <= conv_idle;
                end
                default: state <= conv_idle;
            endcase
        end
    end

    always_ff @(posedge clk_tube) begin
        if (state == conv_idle && req.valid) begin
            shift_val <= req.value;
            mode_q    <= req.mode;
            bcd       <= '0;
        end else if (state == conv_shift) begin
            if (mode_q == mode_binary) begin
                bcd <= bin_load;
            end else begin
                bcd       <= {bcd_adj[4*bcd_digits-2:0], shift_val[val_w-1]}; // msb first
                shift_val <= {shift_val[val_w-2:0], 1'b0};
            end
        end
    end

    assign req.ready  = (state == conv_idle);
    assign dig.valid  = (state == conv_hold);
    assign dig.digits = bcd[4*digit_count-1:0];
    assign dig.mode   = mode_q;

    // the scanner may hold us off for most of a frame, the digits must not move
    digits_hold_a: assert property (@(posedge clk_tube) disable iff (!rst_n)
        dig.valid && !dig.ready |=> dig.valid && $stable(dig.digits) && $stable(dig.mode))
        else $error("digit bus changed while stalled");

endmodule

//--- source/value_intake.sv
`timescale 1ns/1ps

module value_intake #(
    parameter int val_w = display_pkg::value_width
) (
    input  logic                       clk_tube,
    input  logic                       rst_n,
    input  logic [val_w-1:0]           in_value,
    input  display_pkg::display_mode_e in_mode,
    input  logic                       in_valid,
    output logic                       in_ready,
    display_req_if.source              req
);
    import display_pkg::*;

    logic [val_w-1:0] value_mem [2];
    display_mode_e    mode_mem [2];
    logic             wr_ptr;
    logic             rd_ptr;
    logic [1:0]       count;   // entries held, 0..2
    logic             push;
    logic             pop;

    assign in_ready = (count != 2'd2);
    assign push     = in_valid && in_ready;
    assign pop      = req.valid && req.ready;

    assign req.valid = (count != 2'd0);
    assign req.value = value_mem[rd_ptr];
    assign req.mode  = mode_mem[rd_ptr];

    always_ff @(posedge clk_tube or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) wr_ptr <= ~wr_ptr;
            if (pop) rd_ptr <= ~rd_ptr;
            if (push && !pop) count <= count + 2'd1;
            else if (pop && !push) count <= count - 2'd1;
        end
    end

    always_ff @(posedge clk_tube) begin
        if (push) begin
            value_mem[wr_ptr] <= in_value;
            mode_mem[wr_ptr]  <= in_mode;
        end
    end

    // a write must never land on an entry still waiting to be read
    no_overflow_a: assert property (@(posedge clk_tube) disable iff (!rst_n)
        push |-> (count == 2'd0) || (wr_ptr != rd_ptr))
        else $error("intake FIFO written while full");

endmodule

//--- source/display_if.sv
`timescale 1ns/1ps

// request from the intake FIFO to the converter
interface display_req_if #(
    parameter int val_w = display_pkg::value_width
);
    import display_pkg::*;

    logic [val_w-1:0] value;
    display_mode_e    mode;
    logic             valid;
    logic             ready;

    modport source (
        output value,
        output mode,
        output valid,
        input  ready
    );

    modport sink (
        input  value,
        input  mode,
        input  valid,
        output ready
    );

endinterface

// converted digits from the converter to the scan driver
interface digit_bus_if;
    import display_pkg::*;

    digit_vec_t    digits;
    display_mode_e mode;
    logic          valid;
    logic          ready; // only high at scan position 7

    modport source (
        output digits,
        output mode,
        output valid,
        input  ready
    );

    modport sink (
        input  digits,
        input  mode,
        input  valid,
        output ready
    );

endinterface

//--- source/tube_pkg.sv
package tube_pkg;

    // segments g..a, active low, g in bit 6
    typedef logic [6:0] seg_code_t;

    localparam seg_code_t seg_blank = 7'b111_1111; // dark tube

    localparam logic [7:0] enable_none = 8'b1111_1111; // no position selected

    // scan position 0..7, position 0 is the leftmost tube
    typedef logic [2:0] scan_pos_t;

    function automatic seg_code_t digit_to_seg(input logic [3:0] digit);
        seg_code_t code;
        case (digit)
            4'd0:    code = 7'b100_0000;
            4'd1:    code = 7'b111_1001;
            4'd2:    code = 7'b010_0100;
            4'd3:    code = 7'b011_0000;
            4'd4:    code = 7'b001_1001;
            4'd5:    code = 7'b001_0010;
            4'd6:    code = 7'b000_0010;
            4'd7:    code = 7'b111_1000;
            4'd8:    code = 7'b000_0000;
            4'd9:    code = 7'b001_0000;
            default: code = seg_blank; // not a decimal digit
        endcase
        return code;
    endfunction

endpackage

//--- source/display_pkg.sv
package display_pkg;

    // input value width, enough for 99_999_999 and a little more
    localparam int value_width = 27;

    // tube positions on the board
    localparam int digit_count = 8;

    // one bcd digit
    typedef logic [3:0] digit_t;

    // index 7 is the most significant digit, shown on the leftmost tube
    typedef digit_t [digit_count-1:0] digit_vec_t;

    // how the value is rendered on the tubes
    typedef enum logic {
        mode_decimal = 1'b0, // value mod 10^8 with leading-zero blanking
        mode_binary  = 1'b1  // low eight bits as 0 and 1
    } display_mode_e;

endpackage
